//--- apu_pkg.sv
//##########################################################
// Square channel pair types, bus and tick structs,
// register addresses, duty and length tables
//##########################################################

package apu_pkg;

	typedef logic [10:0] period_t;
	typedef logic [3:0]  volume_t;
	typedef logic [7:0]  len_t;
	typedef logic [3:0]  reg_addr_t; // Wishbone word address

	// Per-channel write port from the register slave
	typedef struct packed {
		logic [3:0] wr;   // One strobe per channel register
		logic [7:0] data;
		logic       clr;  // Channel disabled
	} sq_bus_t;

	typedef struct packed {
		logic quarter;
		logic half;
	} frame_tick_t;

	localparam reg_addr_t ADDR_SQ0_BASE = 4'd0;
	localparam reg_addr_t ADDR_SQ1_BASE = 4'd4;
	localparam reg_addr_t ADDR_STATUS   = 4'd8;

	// Bit 7 is played first
	localparam logic [7:0] duty_table [4] = '{
		8'b0100_0000,
		8'b0110_0000,
		8'b0111_1000,
		8'b1001_1111
	};

	localparam len_t length_table [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,
		8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,
		8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,
		8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,
		8'd16,  8'd28,  8'd32,  8'd30
	};

endpackage

//--- apu_square_sweep.sv
//##########################################################
// Sweep unit: period register, barrel shifter, adder,
// sweep divider and overflow mute
//##########################################################
`timescale 1ns/1ps

module apu_square_sweep #(
	parameter bit ONES_COMPLEMENT = 1'b0
) (
	input  logic             aclk,
	input  logic             rst_n,
	input  apu_pkg::sq_bus_t bus,
	input  logic             half,
	output apu_pkg::period_t period,
	output logic             mute_sweep
);
	import apu_pkg::*;

	logic        sw_en;
	logic        sw_neg;
	logic [2:0]  sw_div_period;
	logic [2:0]  sw_shift;
	logic [2:0]  div_cnt;
	logic        reload;
	period_t     shift_1;
	period_t     shift_2;
	period_t     shift_3;
	period_t     addend;
	logic        carry_in;
	logic [11:0] sum;
	logic        overflow;
	logic        div_zero;

	// Three stage shifter, by 1, 2 and 4
	assign shift_1 = sw_shift[0] ? {1'b0, period[10:1]} : period;
	assign shift_2 = sw_shift[1] ? {2'b00, shift_1[10:2]} : shift_1;
	assign shift_3 = sw_shift[2] ? {4'b0000, shift_2[10:4]} : shift_2;

	assign addend   = sw_neg ? ~shift_3 : shift_3;
	assign carry_in = sw_neg && !ONES_COMPLEMENT; // Two's complement needs the +1
	assign sum      = {1'b0, period} + {1'b0, addend} + {11'd0, carry_in};
	assign overflow = !sw_neg && sum[11];

	assign mute_sweep = (period < 11'd8) || overflow;
	assign div_zero   = div_cnt == 3'd0;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			period        <= '0;
			sw_en         <= 1'b0;
			sw_neg        <= 1'b0;
			sw_div_period <= 3'd0;
			sw_shift      <= 3'd0;
			div_cnt       <= 3'd0;
			reload        <= 1'b0;
		end else begin
			if (half) begin
				if (div_zero && sw_en && (sw_shift != 3'd0) && !mute_sweep)
					period <= sum[10:0];
				if (div_zero || reload) begin
					div_cnt <= sw_div_period;
					reload  <= 1'b0;
				end else begin
					div_cnt <= div_cnt - 3'd1;
				end
			end
			if (bus.wr[1]) begin
				sw_en         <= bus.data[7];
				sw_div_period <= bus.data[6:4];
				sw_neg        <= bus.data[3];
				sw_shift      <= bus.data[2:0];
				reload        <= 1'b1;
			end
			if (bus.wr[2])
				period[7:0] <= bus.data;
			if (bus.wr[3])
				period[10:8] <= bus.data[2:0];
		end
	end

endmodule

//--- apu_square_timer.sv
//##########################################################
// Period down-counter and duty sequencer
//##########################################################
`timescale 1ns/1ps

module apu_square_timer (
	input  logic             aclk,
	input  logic             rst_n,
	input  apu_pkg::period_t period,
	input  logic             restart,
	input  logic [1:0]       duty,
	output logic             duty_bit
);
	import apu_pkg::*;

	period_t    count;
	logic [2:0] step;
	logic [7:0] pattern;
	logic       reload;

	assign reload = count == '0;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (reload) begin
			count <= period;
		end else begin
			count <= count - 11'd1;
		end
	end

	// Sequencer moves one step per timer reload
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			step <= 3'd0;
		end else if (restart) begin
			step <= 3'd0;
		end else if (reload) begin
			step <= step + 3'd1;
		end
	end

	assign pattern  = duty_table[duty];
	assign duty_bit = pattern[~step]; // Step 0 selects bit 7

endmodule

//--- apu_envelope.sv
//##########################################################
// Volume envelope: divider, decay level, volume select
//##########################################################
`timescale 1ns/1ps

module apu_envelope (
	input  logic             aclk,
	input  logic             rst_n,
	input  logic             quarter,
	input  logic             start,
	input  logic             loop,
	input  logic             const_vol,
	input  apu_pkg::volume_t vol_param,
	output apu_pkg::volume_t volume
);
	import apu_pkg::*;

	logic    start_flag;
	volume_t divider;
	volume_t decay;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			start_flag <= 1'b0;
			divider    <= '0;
			decay      <= '0;
		end else begin
			if (quarter) begin
				if (start_flag) begin
					start_flag <= 1'b0;
					decay      <= 4'd15;
					divider    <= vol_param;
				end else if (divider == '0) begin
					divider <= vol_param;
					if (decay != '0)
						decay <= decay - 4'd1;
					else if (loop)
						decay <= 4'd15; // Looping envelope
				end else begin
					divider <= divider - 4'd1;
				end
			end
			// Pending until the next quarter frame
			if (start)
				start_flag <= 1'b1;
		end
	end

	assign volume = const_vol ? vol_param : decay;

endmodule

//--- apu_square_chan.sv
//##########################################################
// One square channel with length counter and output gate
//##########################################################
`timescale 1ns/1ps

module apu_square_chan #(
	parameter bit ONES_COMPLEMENT = 1'b0
) (
	input  logic                 aclk,
	input  logic                 rst_n,
	input  apu_pkg::sq_bus_t     bus,
	input  apu_pkg::frame_tick_t tick,
	output apu_pkg::volume_t     sample,
	output logic                 len_active
);
	import apu_pkg::*;

	logic [1:0] duty;
	logic       halt;
	logic       const_vol;
	volume_t    vol_param;
	len_t       len_cnt;
	period_t    period;
	logic       mute_sweep;
	logic       duty_bit;
	volume_t    volume;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			duty      <= 2'd0;
			halt      <= 1'b0;
			const_vol <= 1'b0;
			vol_param <= '0;
		end else if (bus.wr[0]) begin
			duty      <= bus.data[7:6];
			halt      <= bus.data[5];
			const_vol <= bus.data[4];
			vol_param <= bus.data[3:0];
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n || bus.clr) begin
			len_cnt <= '0;
		end else if (bus.wr[3]) begin
			len_cnt <= length_table[bus.data[7:3]];
		end else if (tick.half && len_active && !halt) begin
			len_cnt <= len_cnt - 8'd1;
		end
	end

	assign len_active = len_cnt != '0;

	always_ff @(posedge aclk) begin
		if (!rst_n)
			sample <= '0;
		else
			sample <= (duty_bit && len_active && !mute_sweep) ? volume : '0;
	end

	apu_square_sweep #(.ONES_COMPLEMENT(ONES_COMPLEMENT)) u_sweep (
		.aclk(aclk), .rst_n(rst_n), .bus(bus), .half(tick.half),
		.period(period), .mute_sweep(mute_sweep)
	);

	apu_square_timer u_timer (
		.aclk(aclk), .rst_n(rst_n), .period(period), .restart(bus.wr[3]),
		.duty(duty), .duty_bit(duty_bit)
	);

	apu_envelope u_env (
		.aclk(aclk), .rst_n(rst_n), .quarter(tick.quarter), .start(bus.wr[3]),
		.loop(halt), .const_vol(const_vol), .vol_param(vol_param), .volume(volume)
	);

endmodule

//--- apu_square_regs.sv
//##########################################################
// Wishbone classic slave with channel write strobes
// and the enable/status register
//##########################################################
`timescale 1ns/1ps

module apu_square_regs (
	input  logic               aclk,
	input  logic               rst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  apu_pkg::reg_addr_t wb_adr,
	input  logic [7:0]         wb_dat_w,
	input  logic [1:0]         len_active,
	output logic [7:0]         wb_dat_r,
	output logic               wb_ack,
	output apu_pkg::sq_bus_t   sq0_bus,
	output apu_pkg::sq_bus_t   sq1_bus
);
	import apu_pkg::*;

	logic       req;
	logic       wr_req;
	logic       sel_sq0;
	logic       sel_sq1;
	logic       sel_status;
	logic [3:0] reg_sel;
	logic [3:0] sq0_wr;
	logic [3:0] sq1_wr;
	logic [7:0] wr_data;
	logic [1:0] enable;

	assign req        = wb_cyc && wb_stb && !wb_ack; // No back-to-back ack
	assign wr_req     = req && wb_we;
	assign sel_sq0    = wb_adr[3:2] == ADDR_SQ0_BASE[3:2];
	assign sel_sq1    = wb_adr[3:2] == ADDR_SQ1_BASE[3:2];
	assign sel_status = wb_adr == ADDR_STATUS;
	assign reg_sel    = 4'b0001 << wb_adr[1:0];

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			sq0_wr <= '0;
			sq1_wr <= '0;
			enable <= '0;
		end else begin
			wb_ack <= req;
			sq0_wr <= (wr_req && sel_sq0) ? reg_sel : 4'b0000;
			sq1_wr <= (wr_req && sel_sq1) ? reg_sel : 4'b0000;
			if (wr_req && sel_status)
				enable <= wb_dat_w[1:0];
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_req)
			wr_data <= wb_dat_w;
		if (req && !wb_we)
			wb_dat_r <= sel_status ? {6'b000000, len_active} : 8'h00; // Unmapped reads 0
	end

	assign sq0_bus = '{wr: sq0_wr, data: wr_data, clr: !enable[0]};
	assign sq1_bus = '{wr: sq1_wr, data: wr_data, clr: !enable[1]};

endmodule

//--- apu_frame_seq.sv
//##########################################################
// Four-step frame sequencer, quarter and half frame ticks
//##########################################################
`timescale 1ns/1ps

module apu_frame_seq #(
	parameter int FRAME_DIV = 7457
) (
	input  logic                 aclk,
	input  logic                 rst_n,
	output apu_pkg::frame_tick_t tick
);

	localparam int CNT_W = $clog2(FRAME_DIV);

	logic [CNT_W-1:0] div_cnt;
	logic [1:0]       step;
	logic             div_done;

	assign div_done = div_cnt == CNT_W'(FRAME_DIV - 1);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			step    <= 2'd0;
			tick    <= '0;
		end else begin
			tick.quarter <= div_done;
			// Half frame on steps 1 and 3
			tick.half    <= div_done && ((step == 2'd1) || (step == 2'd3));
			if (div_done) begin
				div_cnt <= '0;
				step    <= step + 2'd1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

//--- apu_square_pair.sv
//##########################################################
// Square pair top: bus slave, frame sequencer, two channels
//##########################################################
`timescale 1ns/1ps

module apu_square_pair #(
	parameter int FRAME_DIV = 7457
) (
	input  logic               aclk,
	input  logic               rst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  apu_pkg::reg_addr_t wb_adr,
	input  logic [7:0]         wb_dat_w,
	output logic [7:0]         wb_dat_r,
	output logic               wb_ack,
	output apu_pkg::volume_t   sq0_sample,
	output apu_pkg::volume_t   sq1_sample
);
	import apu_pkg::*;

	sq_bus_t     sq0_bus;
	sq_bus_t     sq1_bus;
	frame_tick_t tick;
	logic [1:0]  len_active;

	apu_square_regs u_regs (
		.aclk(aclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .len_active(len_active),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .sq0_bus(sq0_bus), .sq1_bus(sq1_bus)
	);

	apu_frame_seq #(.FRAME_DIV(FRAME_DIV)) u_frame (.aclk(aclk), .rst_n(rst_n), .tick(tick));

	apu_square_chan #(.ONES_COMPLEMENT(1'b1)) u_sq0 (   // Carry-in tied off
		.aclk(aclk), .rst_n(rst_n), .bus(sq0_bus), .tick(tick),
		.sample(sq0_sample), .len_active(len_active[0])
	);

	apu_square_chan #(.ONES_COMPLEMENT(1'b0)) u_sq1 (
		.aclk(aclk), .rst_n(rst_n), .bus(sq1_bus), .tick(tick),
		.sample(sq1_sample), .len_active(len_active[1])
	);

endmodule

//--- apu_square_checker.sv
//##########################################################
// Bound assertions on the Wishbone ack and reset
//##########################################################
`timescale 1ns/1ps

module apu_square_checker (
	input logic aclk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	ack_needs_req: assert property (@(posedge aclk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb)) else $error("ack without a request");

	ack_single: assert property (@(posedge aclk) disable iff (!rst_n)
		wb_ack |=> !wb_ack) else $error("ack high for two cycles");

	ack_reset: assert property (@(posedge aclk)
		!rst_n |=> !wb_ack) else $error("ack high during reset");

endmodule

bind apu_square_regs apu_square_checker u_checker (
	.aclk(aclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
);

//--- tb_apu_square.sv
//##########################################################
// Directed testbench: clock, reset, Wishbone tasks, tests
//##########################################################
`timescale 1ns/1ps

module tb_apu_square;
	import apu_pkg::*;

	logic      aclk;
	logic      rst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic      wb_ack;
	volume_t   sq0_sample;
	volume_t   sq1_sample;
	integer    seed;

	apu_square_pair #(.FRAME_DIV(64)) u_dut (
		.aclk(aclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.sq0_sample(sq0_sample), .sq1_sample(sq1_sample)
	);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else
			fail_now($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// One classic cycle, returns read data with the ack
	task automatic bus_cycle(input reg_addr_t adr, input logic we, input logic [7:0] wdat,
			output logic [7:0] rdat);
		int n;
		@(posedge aclk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		n = 0;
		do begin
			@(posedge aclk);
			n++;
			if (n > 20)
				fail_now("Wishbone access got no acknowledge in time");
		end while (!wb_ack);
		rdat = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input reg_addr_t adr, input logic [7:0] data);
		logic [7:0] unused;
		bus_cycle(adr, 1'b1, data, unused);
	endtask

	task automatic wb_read(input reg_addr_t adr, output logic [7:0] data);
		bus_cycle(adr, 1'b0, 8'h00, data);
	endtask

	task automatic set_channel(input int ch, input logic [7:0] r0, input logic [7:0] r1,
			input logic [7:0] r2, input logic [7:0] r3);
		reg_addr_t base;
		base = (ch == 0) ? ADDR_SQ0_BASE : ADDR_SQ1_BASE;
		wb_write(base, r0);
		wb_write(base + 4'd1, r1);
		wb_write(base + 4'd2, r2);
		wb_write(base + 4'd3, r3);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge aclk);
	endtask

	task automatic wait_half();
		int n;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
			if (n > 400)
				fail_now("No half frame tick seen in time");
		end while (!u_dut.tick.half);
	endtask

	task automatic check_status(input logic [7:0] exp);
		logic [7:0] st;
		wb_read(ADDR_STATUS, st);
		check_eq("wb_dat_r", st, exp);
	endtask

	// Cycles between the first and second level change of a channel sample
	task automatic measure_run(input int ch, output int len);
		volume_t last;
		int n;
		int edges;
		@(negedge aclk);
		last  = (ch == 0) ? sq0_sample : sq1_sample;
		n     = 0;
		edges = 0;
		len   = 0;
		while (edges < 2) begin
			@(negedge aclk);
			n++;
			len++;
			if (n > 3000)
				fail_now("Sample level did not change in time");
			if (((ch == 0) ? sq0_sample : sq1_sample) != last) begin
				last = (ch == 0) ? sq0_sample : sq1_sample;
				edges++;
				if (edges == 1)
					len = 0;
			end
		end
	endtask

	task automatic wait_level(input volume_t lvl, input int limit);
		int n;
		n = 0;
		while (sq0_sample != lvl) begin
			@(negedge aclk);
			n++;
			if (n > limit)
				fail_now("Envelope level never reached the expected value");
		end
	endtask

	task automatic check_silent(input int n);
		repeat (n) begin
			@(negedge aclk);
			check_eq("sq0_sample", sq0_sample, 0);
		end
	endtask

	task automatic test_bus_status();
		check_status(8'h00);
		wb_write(ADDR_STATUS, 8'h03);
		wb_write(ADDR_SQ0_BASE + 4'd3, 8'h08);
		wb_write(ADDR_SQ1_BASE + 4'd3, 8'h08);
		check_status(8'h03);
		wb_write(ADDR_STATUS, 8'h01);
		check_status(8'h01);
	endtask

	task automatic test_waveform();
		int p;
		int hi;
		int exp_hi;
		volume_t vol;
		int highs [4];
		highs = '{1, 2, 4, 6};
		for (int d = 0; d < 4; d++) begin
			p   = 8 + ($random(seed) & 63);
			vol = volume_t'(($random(seed) & 15) | 1);
			set_channel(0, 8'((d << 6) | 8'h30 | vol), 8'h00, 8'(p), 8'h08);
			wait_cycles(16 * (p + 1));
			hi     = 0;
			exp_hi = highs[d] * (p + 1);
			repeat (8 * (p + 1)) begin
				@(negedge aclk);
				if (sq0_sample == vol)
					hi++;
				else
					check_eq("sq0_sample", sq0_sample, 0);
			end
			check_eq("sq0_sample high cycles", hi, exp_hi);
		end
	endtask

	task automatic test_length();
		set_channel(0, 8'h9F, 8'h00, 8'h08, 8'h08);
		wait_cycles(600);
		check_status(8'h01);
		wait_half();
		wb_write(ADDR_SQ0_BASE + 4'd3, 8'h18); // Length 2
		wait_half();
		check_status(8'h01);
		wait_half();
		check_status(8'h00);
		check_silent(200);
	endtask

	task automatic test_envelope();
		volume_t last_nz;
		set_channel(0, 8'h80, 8'h00, 8'h08, 8'h08);
		wait_level(4'd15, 300);
		last_nz = 4'd15;
		repeat (1300) begin
			@(negedge aclk);
			if (sq0_sample != 0) begin
				assert (sq0_sample <= last_nz) else
					fail_now($sformatf("** Error: sq0_sample rose to 0x%0h from 0x%0h",
						sq0_sample, last_nz));
				last_nz = sq0_sample;
			end
		end
		check_silent(150);
		wb_write(ADDR_SQ0_BASE, 8'hA0); // Loop on
		wait_level(4'd15, 300);
	endtask

	task automatic test_sweep_negate();
		int len;
		wb_write(ADDR_STATUS, 8'h03);
		set_channel(0, 8'hBF, 8'h00, 8'h00, 8'h09);
		set_channel(1, 8'hBF, 8'h00, 8'h00, 8'h09);
		wait_half();
		wb_write(ADDR_SQ0_BASE + 4'd1, 8'h89);
		wb_write(ADDR_SQ1_BASE + 4'd1, 8'h89);
		wait_half();
		wb_write(ADDR_SQ0_BASE + 4'd1, 8'h08); // Freeze the swept period
		wb_write(ADDR_SQ1_BASE + 4'd1, 8'h08);
		measure_run(0, len);
		check_eq("sq0 period", len / 4 - 1, 32'h7F);
		measure_run(1, len);
		check_eq("sq1 period", len / 4 - 1, 32'h80);
	endtask

	task automatic test_sweep_mute();
		set_channel(0, 8'hBF, 8'h01, 8'h00, 8'h0F);
		check_silent(8 * 32'h701);
		set_channel(0, 8'hBF, 8'h00, 8'h05, 8'h08);
		for (int d = 0; d < 4; d++) begin
			wb_write(ADDR_SQ0_BASE, 8'((d << 6) | 8'h3F));
			check_silent(200);
		end
	endtask

	initial begin
		seed     = 69;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = 8'h00;
		repeat (5) @(posedge aclk);
		rst_n <= 1'b1;
		test_bus_status();
		test_waveform();
		test_length();
		test_envelope();
		test_sweep_negate();
		test_sweep_mute();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- sources.f
apu_pkg.sv
apu_square_sweep.sv
apu_square_timer.sv
apu_envelope.sv
apu_square_chan.sv
apu_square_regs.sv
apu_frame_seq.sv
apu_square_pair.sv
apu_square_checker.sv
tb_apu_square.sv

//--- Makefile
TOP = tb_apu_square

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
